// ==== core_top.f ====
rtl/core_pkg.sv
rtl/core_fetch.sv
rtl/core_regfile.sv
rtl/core_decode.sv
rtl/core_execute.sv
rtl/core_control.sv
rtl/core_top.sv
dv/core_tb.sv

// ==== dv/core_tb.sv ====
module core_tb;
    import core_pkg::*;

    localparam int clock_period = 8;
    localparam int num_runs = 26;                     // Programs started over all tests.
    localparam int watchdog_cycles = num_runs * 64 * 8 + 4000;

    logic clock;
    logic reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    logic [inst_width-1:0] prog [imem_depth];
    int prog_len;
    reg_data_t expected [32];
    logic [apb_data_width-1:0] expected_status;
    int errors;
    int checks;
    int tests;
    int test_start_errors;
    event run_done;
    event check_done;

    core_top dut_i (
        .clock(clock),
        .reset(reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("Watchdog expired after %0d cycles, the run is stopped", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    // ####################
    // Encoding and model.
    // ####################
    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {op_special, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] alu_funct(input int k);
        case (k)
            0: return funct_addu;
            1: return funct_subu;
            2: return funct_and;
            3: return funct_or;
            default: return funct_slt;
        endcase
    endfunction

    function automatic void emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endfunction

    function automatic reg_data_t sext16(input logic [15:0] v);
        return {{48{v[15]}}, v};
    endfunction

    function automatic void model_run();
        reg_data_t r [32];
        logic [31:0] w;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] dest;
        reg_data_t value;
        logic write;
        logic done;
        int idx;
        int steps;
        for (int k = 0; k < 32; k++) begin
            r[k] = expected[k];                            // Registers survive a restart.
        end
        idx = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4096) begin
            w = prog[idx];
            rs = w[25:21];
            rt = w[20:16];
            dest = rt;
            value = '0;
            write = 1'b0;
            steps++;
            case (w[31:26])
                op_special: begin
                    dest = w[15:11];
                    write = 1'b1;
                    case (w[5:0])
                        funct_addu: value = r[rs] + r[rt];
                        funct_subu: value = r[rs] - r[rt];
                        funct_and: value = r[rs] & r[rt];
                        funct_or: value = r[rs] | r[rt];
                        funct_slt: value = ($signed(r[rs]) < $signed(r[rt])) ? 64'd1 : 64'd0;
                        default: write = 1'b0;             // Unknown funct is a no-op.
                    endcase
                end
                op_addiu: begin
                    write = 1'b1;
                    value = r[rs] + sext16(w[15:0]);
                end
                op_lui: begin
                    write = 1'b1;
                    value = sext16(w[15:0]) << 16;
                end
                op_beq, op_bne: begin
                    if ((r[rs] == r[rt]) == (w[31:26] == op_beq)) begin
                        idx = idx + int'($signed(w[15:0]));  // No delay slot.
                    end
                end
                op_halt: done = 1'b1;
                default: ;
            endcase
            if (write && dest != 5'd0) begin
                r[dest] = value;
            end
            idx = (idx + 1) & (imem_depth - 1);
        end
        for (int k = 0; k < 32; k++) begin
            expected[k] = r[k];
        end
    endfunction

    // ####################
    // APB and checks.
    // ####################
    task automatic apb_transfer(input logic write, input logic [apb_addr_width-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clock);
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = write;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(negedge clock);
        apb_req.penable = 1'b1;
        #(clock_period / 4);                               // Mid access phase.
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        if (!apb_rsp.pready) begin
            errors++;
            $display("APB access to %h at %0t saw pready low", addr, $time);
        end
        @(negedge clock);
        apb_req = '0;
    endtask

    task automatic compare_reg(input string name, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_status(input string name, input logic [apb_data_width-1:0] got,
                                  input logic got_err, input logic [apb_data_width-1:0] exp,
                                  input logic exp_err);
        checks++;
        if (got !== exp || got_err !== exp_err) begin
            errors++;
            $display("Fail t=%0t %s got %h pslverr %b expected %h pslverr %b",
                     $time, name, got, got_err, exp, exp_err);
        end
    endtask

    initial begin : compare_results
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] status;
        logic err_lo;
        logic err_hi;
        forever begin
            @(run_done);
            apb_transfer(1'b0, addr_ctrl, '0, status, err_lo);
            compare_status("status", status, err_lo, expected_status, 1'b0);
            for (int n = 0; n < 32; n++) begin
                apb_transfer(1'b0, addr_reg_base + 12'(n * 8), '0, lo, err_lo);
                apb_transfer(1'b0, addr_reg_base + 12'(n * 8 + 4), '0, hi, err_hi);
                if (err_lo || err_hi) begin
                    errors++;
                    $display("Read of register %0d was refused with pslverr", n);
                end
                compare_reg($sformatf("r%0d", n), {hi, lo}, expected[n]);
            end
            -> check_done;
        end
    end

    task automatic apply_reset();
        reset = 1'b1;
        for (int k = 0; k < 32; k++) begin
            expected[k] = '0;
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic load_and_start(input logic reserved);
        logic [31:0] rdata;
        logic err;
        for (int i = 0; i < prog_len; i++) begin
            apb_transfer(1'b1, addr_imem_base + 12'(i * 4), prog[i], rdata, err);
            compare_status($sformatf("imem write %0d", i), rdata, err, '0, 1'b0);
        end
        model_run();
        expected_status = {29'd0, reserved, 2'b10};        // Halted, never running at the end.
        apb_transfer(1'b1, addr_ctrl, 32'd1, rdata, err);
        compare_status("start write", rdata, err, '0, 1'b0);
    endtask

    task automatic finish_run();
        logic [31:0] status;
        logic err;
        logic halted;
        halted = 1'b0;
        for (int poll = 0; poll < 400 && !halted; poll++) begin
            apb_transfer(1'b0, addr_ctrl, '0, status, err);
            halted = status[1];
        end
        if (!halted) begin
            errors++;
            $display("Core did not report halted within the polling limit at %0t", $time);
        end else begin
            -> run_done;
            @(check_done);
        end
    endtask

    task automatic report_test(input int n, input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: ok", n, name);
        end else begin
            $display("Test %0d %s: %0d errors", n, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // ####################
    // Tests.
    // ####################
    initial begin
        logic [31:0] rdata;
        logic err;
        int kind;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        void'($urandom(32'h7824));
        apb_req = '0;
        reset = 1'b1;
        errors = 0;
        checks = 0;
        tests = 0;
        test_start_errors = 0;
        prog_len = 0;
        expected_status = '0;
        apply_reset();

        emit(i_type(op_addiu, 5'd0, 5'd1, 16'h1234));
        emit(i_type(op_addiu, 5'd1, 5'd2, 16'hFFFB));
        emit(i_type(op_lui, 5'd0, 5'd3, 16'h8001));
        emit(r_type(funct_addu, 5'd4, 5'd3, 5'd2));
        emit(r_type(funct_subu, 5'd5, 5'd4, 5'd1));
        emit(r_type(funct_and, 5'd6, 5'd5, 5'd4));
        emit(r_type(funct_or, 5'd7, 5'd6, 5'd3));
        emit(r_type(funct_slt, 5'd8, 5'd3, 5'd1));
        emit(r_type(funct_slt, 5'd9, 5'd1, 5'd3));
        emit(r_type(funct_addu, 5'd10, 5'd9, 5'd8));
        emit(r_type(funct_subu, 5'd11, 5'd0, 5'd1));
        emit(r_type(funct_addu, 5'd12, 5'd11, 5'd11));
        emit(i_type(op_halt, 5'd0, 5'd0, 16'd0));
        load_and_start(1'b0);
        finish_run();
        report_test(1, "alu forwarding");

        prog_len = 0;
        emit(i_type(op_addiu, 5'd0, 5'd1, 16'd5));
        emit(i_type(op_addiu, 5'd0, 5'd2, 16'd5));
        emit(i_type(op_addiu, 5'd0, 5'd3, 16'd7));
        emit(i_type(op_beq, 5'd1, 5'd2, 16'd2));          // Taken.
        emit(i_type(op_addiu, 5'd0, 5'd10, 16'h0BAD));
        emit(i_type(op_addiu, 5'd0, 5'd11, 16'h0BAD));
        emit(i_type(op_addiu, 5'd0, 5'd4, 16'd1));
        emit(i_type(op_bne, 5'd1, 5'd2, 16'd1));          // Not taken.
        emit(i_type(op_addiu, 5'd0, 5'd5, 16'd2));
        emit(i_type(op_bne, 5'd1, 5'd3, 16'd2));          // Taken.
        emit(i_type(op_addiu, 5'd0, 5'd12, 16'h0BAD));
        emit(i_type(op_addiu, 5'd0, 5'd13, 16'h0BAD));
        emit(i_type(op_beq, 5'd1, 5'd3, 16'd1));          // Not taken.
        emit(i_type(op_addiu, 5'd0, 5'd6, 16'd3));
        emit(i_type(op_halt, 5'd0, 5'd0, 16'd0));
        load_and_start(1'b0);
        finish_run();
        report_test(2, "branches");

        for (int p = 0; p < 20; p++) begin
            prog_len = 0;
            for (int i = 0; i < 40; i++) begin
                kind = int'($urandom_range(0, 9));
                rd = 5'($urandom_range(0, 7));
                rs = 5'($urandom_range(0, 7));
                rt = 5'($urandom_range(0, 7));
                if (kind < 5) begin
                    emit(r_type(alu_funct(kind), rd, rs, rt));
                end else if (kind < 7) begin
                    emit(i_type(op_addiu, rs, rt, 16'($urandom)));
                end else if (kind == 7) begin
                    emit(i_type(op_lui, 5'd0, rt, 16'($urandom)));
                end else begin
                    // Forward only, never past the HALT at index 40.
                    emit(i_type(kind == 8 ? op_beq : op_bne, rs, rt,
                                16'($urandom_range(0, (39 - i) < 3 ? (39 - i) : 3))));
                end
            end
            emit(i_type(op_halt, 5'd0, 5'd0, 16'd0));
            load_and_start(1'b0);
            finish_run();
        end
        report_test(3, "random programs");

        prog_len = 0;
        emit(i_type(op_addiu, 5'd0, 5'd0, 16'h0055));
        emit(i_type(op_addiu, 5'd0, 5'd1, 16'h0010));
        emit(r_type(funct_addu, 5'd0, 5'd1, 5'd1));
        emit(i_type(6'h3E, 5'd1, 5'd1, 16'h1234));      // Undefined opcode.
        emit(r_type(6'h20, 5'd2, 5'd1, 5'd1));          // Undefined funct.
        emit(r_type(funct_addu, 5'd3, 5'd0, 5'd1));
        emit(i_type(op_halt, 5'd0, 5'd0, 16'd0));
        load_and_start(1'b1);
        finish_run();
        report_test(4, "register zero and reserved");

        apply_reset();
        apb_transfer(1'b0, addr_ctrl, '0, rdata, err);
        compare_status("status after reset", rdata, err, '0, 1'b0);
        prog_len = 0;
        emit(i_type(op_beq, 5'd0, 5'd0, 16'hFFFF));     // Spins on itself.
        load_and_start(1'b0);
        apb_transfer(1'b1, addr_imem_base + 12'd4, 32'h0, rdata, err);
        compare_status("imem write while running", rdata, err, '0, 1'b1);
        apb_transfer(1'b0, addr_reg_base + 12'd8, '0, rdata, err);
        compare_status("register read while running", rdata, err, '0, 1'b1);
        apb_transfer(1'b1, addr_reg_base, 32'h1, rdata, err);
        compare_status("register write", rdata, err, '0, 1'b1);
        apb_transfer(1'b0, 12'h400, '0, rdata, err);
        compare_status("unmapped read", rdata, err, '0, 1'b1);
        apb_transfer(1'b0, addr_ctrl, '0, rdata, err);
        compare_status("status while running", rdata, err, 32'h1, 1'b0);
        apply_reset();
        apb_transfer(1'b0, addr_ctrl, '0, rdata, err);
        compare_status("status after second reset", rdata, err, '0, 1'b0);
        apb_transfer(1'b1, addr_reg_base + 12'h0F8, 32'h5, rdata, err);
        compare_status("register write while idle", rdata, err, '0, 1'b1);
        apb_transfer(1'b1, 12'h010, 32'h1, rdata, err);
        compare_status("unmapped write", rdata, err, '0, 1'b1);
        report_test(5, "apb errors");

        prog_len = 0;
        emit(i_type(op_addiu, 5'd0, 5'd1, 16'd7));
        emit(i_type(6'h3E, 5'd0, 5'd0, 16'd0));
        emit(r_type(funct_addu, 5'd2, 5'd1, 5'd1));
        emit(i_type(op_halt, 5'd0, 5'd0, 16'd0));
        load_and_start(1'b1);
        finish_run();
        prog_len = 0;
        for (int i = 0; i < 10; i++) begin
            emit(i_type(op_addiu, 5'd1, 5'd1, 16'd3));
            emit(r_type(funct_addu, 5'd2, 5'd2, 5'd1));
        end
        emit(i_type(op_halt, 5'd0, 5'd0, 16'd0));
        load_and_start(1'b0);
        apb_transfer(1'b0, addr_ctrl, '0, rdata, err);
        compare_status("status after restart", rdata, err, 32'h1, 1'b0);
        finish_run();
        report_test(6, "restart");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== rtl/core_control.sv ====
module core_control (
    input logic clock,
    input logic reset,
    input core_pkg::apb_req_t apb_req,
    output core_pkg::apb_rsp_t apb_rsp,
    input core_pkg::redirect_t redirect,
    input logic halt_seen,
    input logic reserved_seen_pulse,
    output logic [core_pkg::reg_index_width-1:0] host_reg_index,
    input core_pkg::reg_data_t host_reg_data,
    output core_pkg::imem_write_t imem_write,
    output core_pkg::pipe_ctl_t pipe_ctl
);
    import core_pkg::*;

    logic access;
    logic hit_ctrl;
    logic hit_imem;
    logic hit_reg;
    logic start;
    logic running;
    logic halted;
    logic reserved_seen;
    logic start_flush;
    logic [apb_addr_width-1:0] imem_offset;
    logic [apb_addr_width-1:0] reg_offset;
    logic [apb_data_width-1:0] status;
    logic [apb_data_width-1:0] reg_word;

    // ####################
    // Address decode.
    // ####################
    assign access = apb_req.psel & apb_req.penable;
    assign imem_offset = apb_req.paddr - addr_imem_base;
    assign reg_offset = apb_req.paddr - addr_reg_base;

    // Addresses below a window wrap to large offsets and miss it.
    assign hit_ctrl = (apb_req.paddr == addr_ctrl);
    assign hit_imem = int'(imem_offset) < imem_depth * 4 && apb_req.paddr[1:0] == 2'b00;
    assign hit_reg = int'(reg_offset) < (2**reg_index_width) * 8 && apb_req.paddr[1:0] == 2'b00;

    assign host_reg_index = reg_offset[reg_index_width+2:3];
    assign reg_word = reg_offset[2] ? host_reg_data[63:32] : host_reg_data[31:0];
    assign status = {{(apb_data_width-3){1'b0}}, reserved_seen, halted, running};

    always_comb begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = '0;
        apb_rsp.pslverr = 1'b0;
        if (access) begin
            if (hit_ctrl) begin
                if (!apb_req.pwrite) begin
                    apb_rsp.prdata = status;
                end
            end else if (hit_imem && apb_req.pwrite && !running) begin
                apb_rsp.prdata = '0;                // Load goes through imem_write.
            end else if (hit_reg && !apb_req.pwrite && !running) begin
                apb_rsp.prdata = reg_word;
            end else begin
                apb_rsp.pslverr = 1'b1;
            end
        end
    end

    assign start = access & apb_req.pwrite & hit_ctrl & apb_req.pwdata[0];

    assign imem_write.enable = access & apb_req.pwrite & hit_imem & ~running;
    assign imem_write.index = imem_offset[imem_index_width+1:2];
    assign imem_write.data = apb_req.pwdata;

    // ####################
    // Run state.
    // ####################
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            halted <= 1'b0;
            reserved_seen <= 1'b0;
            start_flush <= 1'b0;
        end else begin
            start_flush <= start;
            if (start) begin
                running <= 1'b1;
                halted <= 1'b0;
                reserved_seen <= 1'b0;
            end else begin
                if (halt_seen) begin
                    running <= 1'b0;
                    halted <= 1'b1;
                end
                if (reserved_seen_pulse) begin
                    reserved_seen <= 1'b1;
                end
            end
        end
    end

    assign pipe_ctl.run = running;
    assign pipe_ctl.flush = start_flush | redirect.taken;   // Start clears pc to zero.

endmodule

// ==== rtl/core_decode.sv ====
module core_decode (
    input logic clock,
    input logic reset,
    input core_pkg::if_regs_t if_regs,
    input core_pkg::pipe_ctl_t pipe_ctl,
    input core_pkg::wb_regs_t wb,
    output core_pkg::id_regs_t id_regs,
    input logic [core_pkg::reg_index_width-1:0] host_reg_index,
    output core_pkg::reg_data_t host_reg_data,
    output logic reserved_seen_pulse
);
    import core_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [reg_index_width-1:0] rs;
    logic [reg_index_width-1:0] rt;
    logic [reg_index_width-1:0] rd;
    logic [reg_index_width-1:0] w_regnum;
    logic [15:0] imm16;
    reg_data_t a_raw;
    reg_data_t b_raw;
    reg_data_t a_fwd;
    reg_data_t b_fwd;
    reg_data_t imm;
    reg_data_t offset;
    reg_data_t pc_branch;
    alu_op_t alu_op;
    logic write_enable;
    logic imm_or_b;
    logic lui;
    logic beq;
    logic bne;
    logic halt;
    logic reserved;

    assign opcode = if_regs.inst[31:26];
    assign rs = if_regs.inst[25:21];
    assign rt = if_regs.inst[20:16];
    assign rd = if_regs.inst[15:11];
    assign imm16 = if_regs.inst[15:0];
    assign funct = if_regs.inst[5:0];

    core_regfile regfile_i (
        .clock(clock),
        .reset(reset),
        .rs(rs),
        .rt(rt),
        .a_data(a_raw),
        .b_data(b_raw),
        .host_index(host_reg_index),
        .host_data(host_reg_data),
        .wb(wb)
    );

    // ####################
    // Decoder.
    // ####################
    always_comb begin
        alu_op = add;
        write_enable = 1'b0;
        w_regnum = rd;
        imm_or_b = 1'b0;
        lui = 1'b0;
        beq = 1'b0;
        bne = 1'b0;
        halt = 1'b0;
        reserved = 1'b0;
        case (opcode)
            op_special: begin
                write_enable = 1'b1;
                case (funct)
                    funct_addu: alu_op = add;
                    funct_subu: alu_op = sub;
                    funct_and: alu_op = and_op;
                    funct_or: alu_op = or_op;
                    funct_slt: alu_op = slt;
                    default: begin
                        write_enable = 1'b0;
                        reserved = 1'b1;
                    end
                endcase
            end
            op_addiu, op_lui: begin
                write_enable = 1'b1;
                w_regnum = rt;                      // Immediates write rt.
                imm_or_b = 1'b1;
                lui = (opcode == op_lui);
            end
            op_beq: beq = 1'b1;
            op_bne: bne = 1'b1;
            op_halt: halt = 1'b1;
            default: reserved = 1'b1;
        endcase
    end

    assign imm = lui ? {{32{imm16[15]}}, imm16, 16'h0000} : {{48{imm16[15]}}, imm16};
    assign offset = {{46{imm16[15]}}, imm16, 2'b00};
    assign pc_branch = if_regs.pc + 64'd4 + offset;

    // The register file writes wb only at the next edge.
    assign a_fwd = (wb.write_enable && wb.w_regnum == rs && rs != '0) ? wb.w_data : a_raw;
    assign b_fwd = (wb.write_enable && wb.w_regnum == rt && rt != '0) ? wb.w_data : b_raw;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            id_regs <= '0;
        end else if (pipe_ctl.flush || !pipe_ctl.run || !if_regs.valid) begin
            id_regs <= '0;                          // Bubble.
        end else begin
            id_regs.valid <= 1'b1;
            id_regs.alu_op <= alu_op;
            id_regs.write_enable <= write_enable;
            id_regs.w_regnum <= w_regnum;
            id_regs.rs <= lui ? '0 : rs;            // LUI adds its immediate to zero.
            id_regs.rt <= rt;
            id_regs.a_data <= lui ? '0 : a_fwd;
            id_regs.b_data <= b_fwd;
            id_regs.imm_or_b <= imm_or_b;
            id_regs.imm <= imm;
            id_regs.pc_branch <= pc_branch;
            id_regs.beq <= beq;
            id_regs.bne <= bne;
            id_regs.halt <= halt;
            id_regs.reserved <= reserved;
        end
    end

    // Flagged once the instruction reaches execute, so flushed ones never count.
    assign reserved_seen_pulse = id_regs.valid & id_regs.reserved & pipe_ctl.run;

endmodule

// ==== rtl/core_execute.sv ====
module core_execute (
    input logic clock,
    input logic reset,
    input core_pkg::id_regs_t id_regs,
    input core_pkg::pipe_ctl_t pipe_ctl,
    output core_pkg::wb_regs_t wb,
    output core_pkg::redirect_t redirect,
    output logic halt_seen
);
    import core_pkg::*;

    reg_data_t a;
    reg_data_t b;
    reg_data_t alu_b;
    reg_data_t result;
    logic active;
    logic equal;

    // The instruction just ahead retired after decode read its operands.
    assign a = (wb.write_enable && wb.w_regnum == id_regs.rs && id_regs.rs != '0)
             ? wb.w_data : id_regs.a_data;
    assign b = (wb.write_enable && wb.w_regnum == id_regs.rt && id_regs.rt != '0)
             ? wb.w_data : id_regs.b_data;
    assign alu_b = id_regs.imm_or_b ? id_regs.imm : b;

    always_comb begin
        case (id_regs.alu_op)
            add: result = a + alu_b;
            sub: result = a - alu_b;
            and_op: result = a & alu_b;
            or_op: result = a | alu_b;
            slt: result = {{(data_width-1){1'b0}}, $signed(a) < $signed(alu_b)};
            default: result = a + alu_b;
        endcase
    end

    assign active = id_regs.valid & pipe_ctl.run;
    assign equal = (a == b);

    assign redirect.taken = active & ((id_regs.beq & equal) | (id_regs.bne & ~equal));
    assign redirect.target = id_regs.pc_branch;
    assign halt_seen = active & id_regs.halt;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else if (pipe_ctl.flush || !active) begin
            wb <= '0;
        end else begin
            wb.write_enable <= id_regs.write_enable;
            wb.w_regnum <= id_regs.w_regnum;
            wb.w_data <= result;
        end
    end

endmodule

// ==== rtl/core_fetch.sv ====
module core_fetch (
    input logic clock,
    input logic reset,
    input core_pkg::imem_write_t imem_write,
    input core_pkg::pipe_ctl_t pipe_ctl,
    input core_pkg::redirect_t redirect,
    output core_pkg::if_regs_t if_regs
);
    import core_pkg::*;

    logic [inst_width-1:0] imem [imem_depth];
    reg_data_t pc;
    logic [imem_index_width-1:0] fetch_index;

    assign fetch_index = pc[imem_index_width+1:2];  // Word index, wraps inside the memory.

    always_ff @(posedge clock) begin
        if (imem_write.enable) begin
            imem[imem_write.index] <= imem_write.data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
            if_regs <= '0;
        end else if (pipe_ctl.flush) begin
            // A flush without a taken branch is the start of a program.
            pc <= redirect.taken ? redirect.target : '0;
            if_regs.valid <= 1'b0;
        end else if (pipe_ctl.run) begin
            pc <= pc + 64'd4;
            if_regs.valid <= 1'b1;
            if_regs.pc <= pc;
            if_regs.inst <= imem[fetch_index];
        end else begin
            if_regs.valid <= 1'b0;          // Pc holds while the core is stopped.
        end
    end

endmodule

// ==== rtl/core_pkg.sv ====
package core_pkg;

    // ####################
    // Sizes and encodings.
    // ####################
    localparam int data_width = 64;
    localparam int inst_width = 32;
    localparam int imem_depth = 64;
    localparam int imem_index_width = 6;
    localparam int reg_index_width = 5;
    localparam int apb_addr_width = 12;
    localparam int apb_data_width = 32;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_lui = 6'h0F;
    localparam logic [5:0] op_beq = 6'h04;
    localparam logic [5:0] op_bne = 6'h05;
    localparam logic [5:0] op_halt = 6'h3F;

    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or = 6'h25;
    localparam logic [5:0] funct_slt = 6'h2A;

    localparam logic [apb_addr_width-1:0] addr_ctrl = 12'h000;
    localparam logic [apb_addr_width-1:0] addr_imem_base = 12'h100;
    localparam logic [apb_addr_width-1:0] addr_reg_base = 12'h200;

    // ####################
    // Bundles.
    // ####################
    typedef enum logic [2:0] {add, sub, and_op, or_op, slt} alu_op_t;

    typedef logic [data_width-1:0] reg_data_t;

    typedef struct packed {
        logic valid;
        reg_data_t pc;                         // Address of the instruction itself.
        logic [inst_width-1:0] inst;
    } if_regs_t;

    typedef struct packed {
        logic valid;
        alu_op_t alu_op;
        logic write_enable;
        logic [reg_index_width-1:0] w_regnum;
        logic [reg_index_width-1:0] rs;
        logic [reg_index_width-1:0] rt;
        reg_data_t a_data;
        reg_data_t b_data;
        logic imm_or_b;                        // Set when the immediate replaces b.
        reg_data_t imm;
        reg_data_t pc_branch;
        logic beq;
        logic bne;
        logic halt;
        logic reserved;
    } id_regs_t;

    typedef struct packed {
        logic write_enable;
        logic [reg_index_width-1:0] w_regnum;
        reg_data_t w_data;
    } wb_regs_t;

    typedef struct packed {
        logic taken;
        reg_data_t target;
    } redirect_t;

    typedef struct packed {
        logic enable;
        logic [imem_index_width-1:0] index;
        logic [inst_width-1:0] data;
    } imem_write_t;

    typedef struct packed {
        logic run;
        logic flush;
    } pipe_ctl_t;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [apb_addr_width-1:0] paddr;
        logic [apb_data_width-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic pready;
        logic [apb_data_width-1:0] prdata;
        logic pslverr;
    } apb_rsp_t;

endpackage

// ==== rtl/core_regfile.sv ====
module core_regfile (
    input logic clock,
    input logic reset,
    input logic [core_pkg::reg_index_width-1:0] rs,
    input logic [core_pkg::reg_index_width-1:0] rt,
    output core_pkg::reg_data_t a_data,
    output core_pkg::reg_data_t b_data,
    input logic [core_pkg::reg_index_width-1:0] host_index,
    output core_pkg::reg_data_t host_data,
    input core_pkg::wb_regs_t wb
);
    import core_pkg::*;

    reg_data_t regs [2**reg_index_width];

    assign a_data = (rs == '0) ? '0 : regs[rs];
    assign b_data = (rt == '0) ? '0 : regs[rt];
    assign host_data = (host_index == '0) ? '0 : regs[host_index];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_index_width; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write_enable && wb.w_regnum != '0) begin
            regs[wb.w_regnum] <= wb.w_data;
        end
    end

endmodule

// ==== rtl/core_top.sv ====
module core_top (
    input logic clock,
    input logic reset,
    input core_pkg::apb_req_t apb_req,
    output core_pkg::apb_rsp_t apb_rsp
);
    import core_pkg::*;

    redirect_t redirect;
    imem_write_t imem_write;
    pipe_ctl_t pipe_ctl;
    if_regs_t if_regs;
    id_regs_t id_regs;
    wb_regs_t wb;
    reg_data_t host_reg_data;
    logic [reg_index_width-1:0] host_reg_index;
    logic halt_seen;
    logic reserved_seen_pulse;

    core_control control_i (
        .clock(clock),
        .reset(reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .redirect(redirect),
        .halt_seen(halt_seen),
        .reserved_seen_pulse(reserved_seen_pulse),
        .host_reg_index(host_reg_index),
        .host_reg_data(host_reg_data),
        .imem_write(imem_write),
        .pipe_ctl(pipe_ctl)
    );

    core_fetch fetch_i (
        .clock(clock),
        .reset(reset),
        .imem_write(imem_write),
        .pipe_ctl(pipe_ctl),
        .redirect(redirect),
        .if_regs(if_regs)
    );

    core_decode decode_i (
        .clock(clock),
        .reset(reset),
        .if_regs(if_regs),
        .pipe_ctl(pipe_ctl),
        .wb(wb),
        .id_regs(id_regs),
        .host_reg_index(host_reg_index),
        .host_reg_data(host_reg_data),
        .reserved_seen_pulse(reserved_seen_pulse)
    );

    core_execute execute_i (
        .clock(clock),
        .reset(reset),
        .id_regs(id_regs),
        .pipe_ctl(pipe_ctl),
        .wb(wb),
        .redirect(redirect),
        .halt_seen(halt_seen)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the core testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module core_tb -f core_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcore_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
